// File: design/menuPkg.sv
`default_nettype none

package menuPkg;

	//////////////////////////////
	// LCD geometry
	localparam int lineLen = 16;
	localparam int lastCell = 31;

	// Cell address, character code and font nibble
	typedef logic [4:0] lcdAddrT;
	typedef logic [7:0] charT;
	typedef logic [3:0] nibbleT;

	// Menu texts in ROM order
	typedef enum logic [2:0] {
		titleMain, optDisplayLocal, optModifyLocal, optClearLocal,
		titleSure, optYes, optNo
	} menuIdT;

	// Data source of one LCD copy job
	typedef enum logic [1:0] {srcMenu, srcRam, srcPicked} srcT;

	// Controller states
	typedef enum logic [3:0] {
		refreshTitle, refreshOption, awaitJob, waitSelect,
		showLocalDone, posSelect, charSelect, clearNow
	} ctrlStateT;

	//////////////////////////////
	// Character constants
	localparam charT blankChar = 8'h20;
	// Column 4 row 1 is 'A'
	localparam nibbleT startColumn = 4'd4;
	localparam nibbleT startRow = 4'd1;

	// One 16 character line per menu text, first character in the top byte
	localparam logic [8*lineLen-1:0] menuText [8] = '{
		"   Main  Menu   ",
		"Display Local   ",
		"Modify Local    ",
		"Clear Local     ",
		"Are you sure?   ",
		"Yes             ",
		"No              ",
		// Spare code, never selected
		"                "
	};

	// Character idx of menu text id
	function automatic charT menuChar(input menuIdT id, input nibbleT idx);
		return menuText[id][8*(lineLen-1-int'(idx)) +: 8];
	endfunction

endpackage

`default_nettype wire

// File: design/lcdJobIf.sv
`timescale 1ns/1ps
`default_nettype none

interface lcdJobIf;
	import menuPkg::*;

	// Request side, held stable from start until done
	logic start;
	lcdAddrT firstAddr;
	lcdAddrT lastAddr;
	srcT source;
	menuIdT menuSel;

	// Writer side
	logic done;
	// Offset of the cell being fetched from firstAddr
	lcdAddrT readIdx;

	modport ctrl (output start, firstAddr, lastAddr, source, menuSel, input done);
	modport writer (input start, firstAddr, lastAddr, source, menuSel, output done, readIdx);

endinterface

`default_nettype wire

// File: design/menuRom.sv
`timescale 1ns/1ps
`default_nettype none

module menuRom (
	input wire clk,
	input wire menuPkg::menuIdT menuSel,
	input wire menuPkg::nibbleT readIdx,
	output menuPkg::charT romData
);
	import menuPkg::*;

	// Text table lookup, one cycle latency
	always_ff @(posedge clk)
	begin
		romData <= menuChar(menuSel, readIdx);
	end

endmodule

`default_nettype wire

// File: design/localRam.sv
`timescale 1ns/1ps
`default_nettype none

module localRam (
	input wire clk,
	input wire reset,
	input wire menuPkg::lcdAddrT readAddr,
	output menuPkg::charT ramData,
	input wire ramWrite,
	input wire menuPkg::lcdAddrT ramWriteAddr,
	input wire menuPkg::charT ramWriteData,
	input wire ramClear
);
	import menuPkg::*;

	// One character per LCD cell
	charT mem [lastCell+1];

	always_ff @(posedge clk)
	begin
		// Blank screen after reset or a clear
		if (reset || ramClear)
		begin
			for (int i = 0; i <= lastCell; i++)
				mem[i] <= blankChar;
		end
		else if (ramWrite)
			mem[ramWriteAddr] <= ramWriteData;
		// Registered read port
		ramData <= mem[readAddr];
	end

endmodule

`default_nettype wire

// File: design/charPicker.sv
`timescale 1ns/1ps
`default_nettype none

module charPicker (
	input wire clk,
	input wire reset,
	input wire menuBtn,
	input wire pickEnable,
	input wire pickShow,
	input wire rotaryEvent,
	input wire rotaryLeft,
	input wire columnLeftBtn,
	input wire columnRightBtn,
	output menuPkg::charT pickedChar,
	output logic changed
);
	import menuPkg::*;

	nibbleT column;
	nibbleT row;
	// Character last sent to the LCD
	charT shownChar;

	assign pickedChar = {column, row};
	assign changed = pickedChar != shownChar;

	always_ff @(posedge clk)
	begin
		if (reset || menuBtn)
		begin
			column <= startColumn;
			row <= startRow;
			shownChar <= {startColumn, startRow};
		end
		else
		begin
			if (pickShow)
				shownChar <= pickedChar;
			if (pickEnable)
			begin
				// Knob steps the row and wins over the buttons
				if (rotaryEvent)
					row <= rotaryLeft ? row + 1'b1 : row - 1'b1;
				else if (columnRightBtn)
				begin
					// Skip columns 8 and 9, wrap 15 to 2
					case (column)
						4'd7: column <= 4'd10;
						4'd15: column <= 4'd2;
						default: column <= column + 1'b1;
					endcase
				end
				else if (columnLeftBtn)
				begin
					case (column)
						4'd10: column <= 4'd7;
						4'd2: column <= 4'd15;
						default: column <= column - 1'b1;
					endcase
				end
			end
		end
	end

	// Column stays on printing columns through every step sequence
	printableColumn: assert property (@(posedge clk) disable iff (reset)
		!(column inside {4'd0, 4'd1, 4'd8, 4'd9}));

endmodule

`default_nettype wire

// File: design/lcdWriter.sv
`timescale 1ns/1ps
`default_nettype none

module lcdWriter (
	input wire clk,
	input wire reset,
	lcdJobIf.writer job,
	input wire menuPkg::charT romData,
	input wire menuPkg::charT ramData,
	input wire menuPkg::charT pickedChar,
	output menuPkg::lcdAddrT lcdAddr,
	output menuPkg::charT lcdData,
	output logic lcdWrite
);
	import menuPkg::*;

	// Setup presents the read address and write strobes the LCD
	typedef enum logic [1:0] {wIdle, wSetup, wWrite} writerStateT;

	writerStateT phase;
	lcdAddrT offset;

	assign job.readIdx = offset;
	assign lcdAddr = job.firstAddr + offset;
	assign lcdWrite = phase == wWrite;

	// Source mux
	always_comb
	begin
		case (job.source)
			srcMenu: lcdData = romData;
			srcRam: lcdData = ramData;
			default: lcdData = pickedChar;
		endcase
	end

	always_ff @(posedge clk)
	begin
		job.done <= 1'b0;
		if (reset)
		begin
			phase <= wIdle;
			offset <= '0;
		end
		else
		begin
			case (phase)
				wIdle:
					if (job.start)
					begin
						offset <= '0;
						phase <= wSetup;
					end
				wSetup:
					phase <= wWrite;
				wWrite:
					// Last cell written, done pulses next cycle
					if (lcdAddr == job.lastAddr)
					begin
						phase <= wIdle;
						job.done <= 1'b1;
					end
					else
					begin
						offset <= offset + 1'b1;
						phase <= wSetup;
					end
				default:
					phase <= wIdle;
			endcase
		end
	end

	// Controller only starts a job on an idle writer
	startWhileIdle: assert property (@(posedge clk) disable iff (reset)
		job.start |-> phase == wIdle);

	// Writes stay inside the requested range
	writeInRange: assert property (@(posedge clk) disable iff (reset)
		lcdWrite |-> (lcdAddr >= job.firstAddr && lcdAddr <= job.lastAddr));

endmodule

`default_nettype wire

// File: design/menuController.sv
`timescale 1ns/1ps
`default_nettype none

module menuController (
	input wire clk,
	input wire reset,
	input wire rotaryEvent,
	input wire rotaryLeft,
	input wire rotaryBtn,
	input wire menuBtn,
	input wire changed,
	input wire menuPkg::charT pickedChar,
	lcdJobIf.ctrl job,
	output logic ramWrite,
	output menuPkg::lcdAddrT ramWriteAddr,
	output menuPkg::charT ramWriteData,
	output logic ramClear,
	output logic pickEnable,
	output logic pickShow,
	output logic cursorEnable,
	output logic cursorLeft,
	output logic cursorRight
);
	import menuPkg::*;

	ctrlStateT state;
	// State to enter once the running job is done
	ctrlStateT afterJob;
	menuIdT option;
	// Inside the are you sure submenu
	logic confirm;
	// Job issued and not yet done
	logic busy;
	lcdAddrT cursorPos;

	// Issue one LCD job and wait for it
	task automatic launch(input lcdAddrT first, input lcdAddrT last, input srcT src,
		input menuIdT sel, input ctrlStateT after);
		job.start <= 1'b1;
		job.firstAddr <= first;
		job.lastAddr <= last;
		job.source <= src;
		job.menuSel <= sel;
		busy <= 1'b1;
		afterJob <= after;
		state <= awaitJob;
	endtask

	assign ramWriteAddr = cursorPos;
	assign ramClear = state == clearNow;
	assign cursorEnable = state == posSelect;
	// Hold the picker while a redraw is pending
	assign pickEnable = state == charSelect && !changed;

	//////////////////////////////
	always_ff @(posedge clk)
	begin
		// One cycle strobes
		job.start <= 1'b0;
		pickShow <= 1'b0;
		ramWrite <= 1'b0;
		cursorLeft <= 1'b0;
		cursorRight <= 1'b0;
		if (job.done)
			busy <= 1'b0;

		if (reset)
		begin
			state <= refreshTitle;
			afterJob <= refreshTitle;
			option <= optDisplayLocal;
			confirm <= 1'b0;
			busy <= 1'b0;
			cursorPos <= '0;
		end
		else if (menuBtn)
		begin
			// Back to the menu, a running job finishes first
			state <= refreshTitle;
			cursorPos <= '0;
			if (confirm)
			begin
				confirm <= 1'b0;
				option <= optClearLocal;
			end
		end
		else
		begin
			case (state)
				refreshTitle:
					if (!busy)
						launch('0, lcdAddrT'(lineLen - 1), srcMenu,
							confirm ? titleSure : titleMain, refreshOption);
				refreshOption:
					launch(lcdAddrT'(lineLen), lcdAddrT'(lastCell), srcMenu, option, waitSelect);
				awaitJob:
					if (job.done)
						state <= afterJob;
				waitSelect:
					if (rotaryBtn)
					begin
						case (option)
							optDisplayLocal:
								launch('0, lcdAddrT'(lastCell), srcRam, option, showLocalDone);
							optModifyLocal:
								launch('0, lcdAddrT'(lastCell), srcRam, option, posSelect);
							optClearLocal:
							begin
								confirm <= 1'b1;
								option <= optYes;
								state <= refreshTitle;
							end
							optYes:
								state <= clearNow;
							default:
							begin
								// No, back to the main ring
								confirm <= 1'b0;
								option <= optDisplayLocal;
								state <= refreshTitle;
							end
						endcase
					end
					else if (rotaryEvent)
					begin
						// Left is next, right is previous
						case (option)
							optDisplayLocal: option <= rotaryLeft ? optModifyLocal : optClearLocal;
							optModifyLocal: option <= rotaryLeft ? optClearLocal : optDisplayLocal;
							optClearLocal: option <= rotaryLeft ? optDisplayLocal : optModifyLocal;
							optYes: option <= optNo;
							default: option <= optYes;
						endcase
						state <= refreshTitle;
					end
				showLocalDone:
					if (rotaryBtn)
						state <= refreshTitle;
				posSelect:
					if (rotaryBtn)
					begin
						// Show the current pick at the cursor cell
						pickShow <= 1'b1;
						launch(cursorPos, cursorPos, srcPicked, option, charSelect);
					end
					else if (rotaryEvent)
					begin
						// Knob left walks the cursor right
						if (rotaryLeft)
						begin
							cursorPos <= cursorPos + 1'b1;
							cursorRight <= 1'b1;
						end
						else
						begin
							cursorPos <= cursorPos - 1'b1;
							cursorLeft <= 1'b1;
						end
					end
				charSelect:
					if (rotaryBtn)
					begin
						// Store the pick and redraw it once more
						ramWrite <= 1'b1;
						ramWriteData <= pickedChar;
						pickShow <= 1'b1;
						launch(cursorPos, cursorPos, srcPicked, option, posSelect);
					end
					else if (changed)
					begin
						pickShow <= 1'b1;
						launch(cursorPos, cursorPos, srcPicked, option, charSelect);
					end
				clearNow:
				begin
					// RAM clears this cycle
					confirm <= 1'b0;
					option <= optDisplayLocal;
					state <= refreshTitle;
				end
				default:
					state <= refreshTitle;
			endcase
		end
	end

	// Store and clear never reach the RAM in the same cycle
	noWriteAndClear: assert property (@(posedge clk) disable iff (reset)
		!(ramWrite && ramClear));

endmodule

`default_nettype wire

// File: design/lcdMenu.sv
`timescale 1ns/1ps
`default_nettype none

module lcdMenu (
	input wire clk,
	input wire reset,
	input wire rotaryEvent,
	input wire rotaryLeft,
	input wire rotaryBtn,
	input wire columnLeftBtn,
	input wire columnRightBtn,
	input wire menuBtn,
	output menuPkg::lcdAddrT lcdAddr,
	output menuPkg::charT lcdData,
	output logic lcdWrite,
	output logic cursorEnable,
	output logic cursorLeft,
	output logic cursorRight
);
	import menuPkg::*;

	charT romData;
	charT ramData;
	charT pickedChar;
	charT ramWriteData;
	lcdAddrT ramWriteAddr;
	logic ramWrite;
	logic ramClear;
	logic pickEnable;
	logic pickShow;
	logic changed;

	//////////////////////////////
	// Controller to writer job link
	lcdJobIf job ();

	menuController uCtrl (
		.clk, .reset, .rotaryEvent, .rotaryLeft, .rotaryBtn, .menuBtn, .changed,
		.pickedChar, .job(job.ctrl), .ramWrite, .ramWriteAddr, .ramWriteData,
		.ramClear, .pickEnable, .pickShow, .cursorEnable, .cursorLeft, .cursorRight
	);

	lcdWriter uWriter (
		.clk, .reset, .job(job.writer), .romData, .ramData, .pickedChar,
		.lcdAddr, .lcdData, .lcdWrite
	);

	// Menu jobs span one line so the low offset bits index the text
	menuRom uRom (.clk, .menuSel(job.menuSel), .readIdx(job.readIdx[3:0]), .romData);

	// RAM jobs start at cell 0 so the offset is the address
	localRam uRam (
		.clk, .reset, .readAddr(job.readIdx), .ramData, .ramWrite, .ramWriteAddr,
		.ramWriteData, .ramClear
	);

	charPicker uPicker (
		.clk, .reset, .menuBtn, .pickEnable, .pickShow, .rotaryEvent, .rotaryLeft,
		.columnLeftBtn, .columnRightBtn, .pickedChar, .changed
	);

endmodule

`default_nettype wire

// File: bench/lcdMenuTb.sv
`timescale 1ns/1ps
`default_nettype none

module lcdMenuTb;
	import menuPkg::*;

	localparam int clkPeriod = 10;
	// Cycles for the longest LCD job plus controller overhead
	localparam int jobCycles = 80;
	// Upper bound on the jobs over all tests
	localparam int maxJobs = 60;
	localparam int budgetCycles = 4 * jobCycles * maxJobs;
	// Bound on one wait for an LCD write
	localparam int waitLimit = 2 * jobCycles;

	logic clk;
	logic reset;
	logic rotaryEvent;
	logic rotaryLeft;
	logic rotaryBtn;
	logic columnLeftBtn;
	logic columnRightBtn;
	logic menuBtn;
	lcdAddrT lcdAddr;
	charT lcdData;
	logic lcdWrite;
	logic cursorEnable;
	logic cursorLeft;
	logic cursorRight;

	// LCD contents as seen through the write port
	charT shadow [32];
	// Expected local memory
	charT memModel [32];
	lcdAddrT writeLog [$];
	// Expected picker column and row
	nibbleT pickColumn;
	nibbleT pickRow;
	// Position in the main option ring
	int ringIdx;
	logic [31:0] rngState;
	int errors;
	int testsRun;
	int failedTests;
	int testStartErrors;

	lcdMenu lcdMenu_i (
		.clk, .reset, .rotaryEvent, .rotaryLeft, .rotaryBtn, .columnLeftBtn,
		.columnRightBtn, .menuBtn, .lcdAddr, .lcdData, .lcdWrite, .cursorEnable,
		.cursorLeft, .cursorRight
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Record every LCD write
	always @(posedge clk)
	begin
		if (lcdWrite === 1'b1)
		begin
			shadow[lcdAddr] = lcdData;
			writeLog.push_back(lcdAddr);
		end
	end

	//////////////////////////////
	// Cursor pulses only while the cursor is shown
	cursorGated: assert property (@(posedge clk) disable iff (reset)
		(cursorLeft || cursorRight) |-> cursorEnable)
	else
	begin
		errors++;
		$display("ERR %0t: cursor pulse while cursorEnable is low", $time);
	end

	// Never both directions at once
	cursorOneWay: assert property (@(posedge clk) disable iff (reset)
		!(cursorLeft && cursorRight))
	else
	begin
		errors++;
		$display("ERR %0t: cursorLeft and cursorRight high together", $time);
	end

	//////////////////////////////
	// Xorshift32
	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Character i of a menu text, leftmost first
	function automatic charT textChar(input menuIdT id, input int i);
		logic [8*lineLen-1:0] line;
		line = menuText[id] << (8 * i);
		return line[8*lineLen-1 -: 8];
	endfunction

	function automatic menuIdT ringOption(input int idx);
		case (idx)
			0: return optDisplayLocal;
			1: return optModifyLocal;
			default: return optClearLocal;
		endcase
	endfunction

	// Columns 0, 1, 8 and 9 hold no printing characters
	function automatic nibbleT nextColumn(input nibbleT col, input logic right);
		nibbleT c;
		c = col;
		do
			c = right ? c + 4'd1 : c - 4'd1;
		while (c inside {4'd0, 4'd1, 4'd8, 4'd9});
		return c;
	endfunction

	//////////////////////////////
	// Advance n edges and land 1 ns after the last
	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic rotate(input logic left);
		rotaryEvent = 1'b1;
		rotaryLeft = left;
		tick(1);
		rotaryEvent = 1'b0;
		rotaryLeft = 1'b0;
	endtask

	task automatic press();
		rotaryBtn = 1'b1;
		tick(1);
		rotaryBtn = 1'b0;
	endtask

	task automatic menuPress();
		menuBtn = 1'b1;
		tick(1);
		menuBtn = 1'b0;
		// Picker goes back to 'A'
		pickColumn = startColumn;
		pickRow = startRow;
	endtask

	task automatic columnStep(input logic right);
		columnRightBtn = right;
		columnLeftBtn = !right;
		tick(1);
		columnRightBtn = 1'b0;
		columnLeftBtn = 1'b0;
	endtask

	// Wait for a write to one cell and for the job to wind down
	task automatic waitCell(input lcdAddrT addr);
		int cycles;
		cycles = 0;
		while (!(lcdWrite === 1'b1 && lcdAddr == addr) && cycles < waitLimit)
		begin
			tick(1);
			cycles++;
		end
		assert (cycles < waitLimit)
		else
		begin
			errors++;
			$display("No LCD write to cell %0d arrived within %0d cycles", addr, waitLimit);
		end
		tick(3);
	endtask

	task automatic expectCell(input int addr, input charT want, input string what);
		assert (shadow[addr] == want)
		else
		begin
			errors++;
			$display("ERR %0t: %s cell %0d shows %h, expected %h", $time, what, addr,
				shadow[addr], want);
		end
	endtask

	task automatic checkMenu(input menuIdT title, input menuIdT opt);
		for (int i = 0; i < lineLen; i++)
		begin
			expectCell(i, textChar(title, i), "title");
			expectCell(lineLen + i, textChar(opt, i), "option");
		end
	endtask

	task automatic checkMemory();
		for (int i = 0; i <= lastCell; i++)
			expectCell(i, memModel[i], "local memory");
	endtask

	// Knob left is next and right is previous
	task automatic turnMenu(input logic left);
		rotate(left);
		ringIdx = left ? (ringIdx + 1) % 3 : (ringIdx + 2) % 3;
		waitCell(lcdAddrT'(lastCell));
		assert (cursorEnable === 1'b0)
		else
		begin
			errors++;
			$display("ERR %0t: cursorEnable high in the menu", $time);
		end
	endtask

	task automatic gotoOption(input int idx);
		while (ringIdx != idx)
			turnMenu(1'b1);
	endtask

	task automatic markTestStart();
		testStartErrors = errors;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors == testStartErrors)
			$display("test %0d %s: ok", testsRun, name);
		else
		begin
			failedTests++;
			$display("test %0d %s: failed", testsRun, name);
		end
	endtask

	//////////////////////////////
	// Watchdog
	initial
	begin
		#(budgetCycles * clkPeriod);
		$display("Timeout: the tests did not finish within %0d cycles", budgetCycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		lcdAddrT k;
		lcdAddrT c;
		int steps;
		int n;
		logic left;
		nibbleT prevCol;

		clk = 1'b0;
		reset = 1'b1;
		rotaryEvent = 1'b0;
		rotaryLeft = 1'b0;
		rotaryBtn = 1'b0;
		columnLeftBtn = 1'b0;
		columnRightBtn = 1'b0;
		menuBtn = 1'b0;
		rngState = 32'd96806;
		errors = 0;
		testsRun = 0;
		failedTests = 0;
		ringIdx = 0;
		pickColumn = startColumn;
		pickRow = startRow;
		for (int i = 0; i < 32; i++)
		begin
			shadow[i] = 8'h00;
			memModel[i] = blankChar;
		end
		tick(4);
		reset = 1'b0;

		// Boot refresh in ascending order
		markTestStart();
		waitCell(lcdAddrT'(lastCell));
		checkMenu(titleMain, optDisplayLocal);
		assert (writeLog.size() == 32)
		else
		begin
			errors++;
			$display("ERR %0t: %0d writes in the boot refresh, expected 32", $time,
				writeLog.size());
		end
		foreach (writeLog[i])
			assert (writeLog[i] == lcdAddrT'(i))
			else
			begin
				errors++;
				$display("ERR %0t: write %0d went to cell %0d", $time, i, writeLog[i]);
			end
		finishTest("boot refresh");

		// Random walk around the option ring
		markTestStart();
		n = 4 + int'(nextRand() % 8);
		repeat (n)
			turnMenu(nextRand() % 2 == 1);
		checkMenu(titleMain, ringOption(ringIdx));
		finishTest("option ring");

		// Edit one character
		markTestStart();
		gotoOption(1);
		press();
		waitCell(lcdAddrT'(lastCell));
		k = lcdAddrT'(1 + nextRand() % 31);
		left = k < 16;
		steps = left ? int'(k) : 32 - int'(k);
		repeat (steps)
		begin
			rotate(left);
			// Knob left walks the cursor right
			assert (cursorRight === left && cursorLeft === !left && cursorEnable === 1'b1)
			else
			begin
				errors++;
				$display("ERR %0t: wrong cursor pulse for a rotation", $time);
			end
			tick(1);
			assert (cursorLeft === 1'b0 && cursorRight === 1'b0)
			else
			begin
				errors++;
				$display("ERR %0t: cursor pulse longer than one cycle", $time);
			end
		end
		press();
		waitCell(k);
		expectCell(k, {pickColumn, pickRow}, "first pick");
		assert (cursorEnable === 1'b0)
		else
		begin
			errors++;
			$display("ERR %0t: cursorEnable high in character select", $time);
		end
		n = 1 + int'(nextRand() % 6);
		repeat (n)
		begin
			rotate(1'b1);
			pickRow = pickRow + 4'd1;
			waitCell(k);
		end
		expectCell(k, {startColumn, nibbleT'(startRow + n)}, "row step");
		// Store and go back to position select
		press();
		memModel[k] = {pickColumn, pickRow};
		waitCell(k);
		menuPress();
		waitCell(lcdAddrT'(lastCell));
		checkMenu(titleMain, optModifyLocal);
		turnMenu(1'b0);
		press();
		waitCell(lcdAddrT'(lastCell));
		checkMemory();
		press();
		waitCell(lcdAddrT'(lastCell));
		finishTest("edit character");

		// Column skipping at cell 0 where the menu button left the cursor
		markTestStart();
		c = '0;
		gotoOption(1);
		press();
		waitCell(lcdAddrT'(lastCell));
		press();
		waitCell(c);
		do
		begin
			prevCol = pickColumn;
			columnStep(1'b1);
			pickColumn = nextColumn(pickColumn, 1'b1);
			waitCell(c);
			expectCell(c, {pickColumn, pickRow}, "column right");
			if (prevCol == 4'd7)
				assert (shadow[c][7:4] == 4'd10)
				else
				begin
					errors++;
					$display("ERR %0t: column 7 stepped right to %0d", $time, shadow[c][7:4]);
				end
		end
		while (pickColumn != 4'd2);
		columnStep(1'b0);
		pickColumn = nextColumn(pickColumn, 1'b0);
		waitCell(c);
		assert (shadow[c][7:4] == 4'd15)
		else
		begin
			errors++;
			$display("ERR %0t: column 2 stepped left to %0d", $time, shadow[c][7:4]);
		end
		press();
		memModel[c] = {pickColumn, pickRow};
		waitCell(c);
		menuPress();
		waitCell(lcdAddrT'(lastCell));
		finishTest("column skip");

		// Clear answered with No
		markTestStart();
		gotoOption(2);
		press();
		waitCell(lcdAddrT'(lastCell));
		checkMenu(titleSure, optYes);
		rotate(1'b1);
		waitCell(lcdAddrT'(lastCell));
		checkMenu(titleSure, optNo);
		press();
		waitCell(lcdAddrT'(lastCell));
		ringIdx = 0;
		checkMenu(titleMain, optDisplayLocal);
		press();
		waitCell(lcdAddrT'(lastCell));
		checkMemory();
		press();
		waitCell(lcdAddrT'(lastCell));
		finishTest("clear no");

		// Clear answered with Yes
		markTestStart();
		gotoOption(2);
		press();
		waitCell(lcdAddrT'(lastCell));
		press();
		waitCell(lcdAddrT'(lastCell));
		ringIdx = 0;
		for (int i = 0; i < 32; i++)
			memModel[i] = blankChar;
		checkMenu(titleMain, optDisplayLocal);
		press();
		waitCell(lcdAddrT'(lastCell));
		checkMemory();
		finishTest("clear yes");

		$display("tests %0d, failed %0d, errors %0d", testsRun, failedTests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
design/menuPkg.sv
design/lcdJobIf.sv
design/menuRom.sv
design/localRam.sv
design/charPicker.sv
design/lcdWriter.sv
design/menuController.sv
design/lcdMenu.sv
bench/lcdMenuTb.sv

// File: Makefile
all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module lcdMenuTb -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
